// ==== Makefile ====
BUILD := obj_dir
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the regression, check the log"
	@echo "  clean  remove the build output and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_uart_subsystem \
		-f uart_subsystem.f --Mdir $(BUILD) -o sim
	./$(BUILD)/sim | tee $(LOG)
	@grep -q "Regression passed" $(LOG) && echo "PASS" || (echo "FAIL" && exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== src/uart_baud_gen.sv ====
module uart_baud_gen #(
    parameter int BAUD_DIV = uart_cfg_pkg::DEFAULT_BAUD_DIV,
    parameter int BAUD_FRAC = uart_cfg_pkg::DEFAULT_BAUD_FRAC
) (
    input  logic clk,
    input  logic reset,
    output logic baud_tick
);

    // Counter must reach the long limit BAUD_DIV+1
    localparam int CW = $clog2(BAUD_DIV + 2);

    logic [CW-1:0] cycle_cnt;
    logic [CW-1:0] limit;
    // Position inside the group of four periods
    logic [1:0]    period_cnt;
    logic          long_period;

    // First BAUD_FRAC periods of each group run one cycle longer
    assign long_period = int'(period_cnt) < BAUD_FRAC;
    assign limit = long_period ? CW'(BAUD_DIV + 1) : CW'(BAUD_DIV);

    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_cnt <= '0;
            period_cnt <= '0;
            baud_tick <= 1'b0;
        end else begin
            if (cycle_cnt == limit) begin
                // End of period, single-cycle enable
                cycle_cnt <= '0;
                baud_tick <= 1'b1;
                // Wraps after four periods
                period_cnt <= period_cnt + 2'd1;
            end else begin
                cycle_cnt <= cycle_cnt + 1'b1;
                baud_tick <= 1'b0;
            end
        end
    end

endmodule

// ==== src/uart_cfg_pkg.sv ====
package uart_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // Frame format
    ////////////////////////////////////////////////////////////

    // 8 data bits, no parity, one stop bit
    localparam int DATA_BITS = 8;

    // Baud ticks per bit on both line sides
    localparam int OVERSAMPLE = 16;

    ////////////////////////////////////////////////////////////
    // Defaults for the top-level parameters
    ////////////////////////////////////////////////////////////

    // Tick period is DIV+1 cycles, one cycle longer in FRAC of every four
    localparam int DEFAULT_BAUD_DIV = 54;
    localparam int DEFAULT_BAUD_FRAC = 1;

    // FIFO depths, also the host transmit credits after reset
    localparam int DEFAULT_TX_DEPTH = 4;
    localparam int DEFAULT_RX_DEPTH = 4;

endpackage

// ==== src/uart_fifo.sv ====
module uart_fifo #(
    parameter int DEPTH = uart_cfg_pkg::DEFAULT_TX_DEPTH,
    parameter type WORD_T = uart_types_pkg::uart_byte_t
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  wr,
    input  WORD_T wr_data,
    input  logic  rd,
    output WORD_T rd_data,
    output logic  empty,
    output logic  full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    WORD_T         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_wr;
    logic          do_rd;

    // Pointer step with wrap for any depth
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Writes to a full or reads from an empty FIFO are ignored
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    assign empty = (count == '0);
    assign full = (count == CW'(DEPTH));

    // Head word always visible
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Occupancy, unchanged on simultaneous write and read
            case ({do_wr, do_rd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== src/uart_rx.sv ====
module uart_rx (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         baud_tick,
    input  logic                         rxd,
    input  logic                         fifo_full,
    output logic                         rx_push,
    output uart_types_pkg::rx_word_t     rx_data,
    output uart_types_pkg::uart_status_t status
);

    localparam int TW = $clog2(uart_cfg_pkg::OVERSAMPLE);
    localparam int BW = $clog2(uart_cfg_pkg::DATA_BITS);
    localparam int NB = uart_cfg_pkg::DATA_BITS;

    uart_types_pkg::rx_state_e  state;
    uart_types_pkg::uart_byte_t shift_reg;
    logic [TW-1:0]              tick_cnt;
    logic [BW-1:0]              bit_cnt;
    logic                       rxd_meta;
    logic                       rxd_sync;
    logic                       mid_tick;
    logic                       last_tick;
    logic                       last_bit;
    logic                       stop_sample;

    // 8th tick after the falling edge, middle of the start bit
    assign mid_tick = (tick_cnt == TW'(uart_cfg_pkg::OVERSAMPLE / 2 - 1));
    assign last_tick = (tick_cnt == TW'(uart_cfg_pkg::OVERSAMPLE - 1));
    assign last_bit = (bit_cnt == BW'(NB - 1));
    assign stop_sample = (state == uart_types_pkg::RX_STOP) && baud_tick && last_tick;

    ////////////////////////////////////////////////////////////
    // Input synchronizer
    ////////////////////////////////////////////////////////////

    // Two flops, line idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    ////////////////////////////////////////////////////////////
    // Data path
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        // Bit centers, LSB arrives first
        if (state == uart_types_pkg::RX_DATA && baud_tick && last_tick) begin
            shift_reg <= {rxd_sync, shift_reg[NB-1:1]};
        end
        if (stop_sample) begin
            rx_data.data <= shift_reg;
            rx_data.frame_err <= !rxd_sync;
        end
    end

    ////////////////////////////////////////////////////////////
    // Frame FSM and sticky status
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= uart_types_pkg::RX_IDLE;
            tick_cnt <= '0;
            bit_cnt <= '0;
            rx_push <= 1'b0;
            status <= '0;
        end else begin
            rx_push <= 1'b0;
            case (state)
                uart_types_pkg::RX_IDLE: begin
                    if (baud_tick && !rxd_sync) begin
                        state <= uart_types_pkg::RX_START;
                        tick_cnt <= '0;
                    end
                end
                uart_types_pkg::RX_START: begin
                    if (baud_tick) begin
                        if (mid_tick) begin
                            // Line back high at mid-bit means a glitch
                            state <= rxd_sync ? uart_types_pkg::RX_IDLE
                                              : uart_types_pkg::RX_DATA;
                            tick_cnt <= '0;
                            bit_cnt <= '0;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                uart_types_pkg::RX_DATA: begin
                    if (baud_tick) begin
                        if (last_tick) begin
                            tick_cnt <= '0;
                            bit_cnt <= bit_cnt + 1'b1;
                            if (last_bit) begin
                                state <= uart_types_pkg::RX_STOP;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                uart_types_pkg::RX_STOP: begin
                    if (baud_tick) begin
                        if (last_tick) begin
                            state <= uart_types_pkg::RX_IDLE;
                            // Full FIFO drops the word
                            rx_push <= !fifo_full;
                            if (fifo_full) begin
                                status.overrun <= 1'b1;
                            end
                            if (!rxd_sync) begin
                                status.frame_err <= 1'b1;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                default: state <= uart_types_pkg::RX_IDLE;
            endcase
        end
    end

endmodule

// ==== src/uart_rx_deliver.sv ====
module uart_rx_deliver #(
    parameter int RX_DEPTH = uart_cfg_pkg::DEFAULT_RX_DEPTH
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     rx_credit,
    input  logic                     fifo_empty,
    input  uart_types_pkg::rx_word_t fifo_data,
    output logic                     fifo_rd,
    output logic                     rx_valid,
    output uart_types_pkg::rx_word_t rx_word
);

    // Headroom for the host granting ahead of a full FIFO
    localparam int CW = $clog2(2 * RX_DEPTH + 1);

    logic [CW-1:0] credits;
    logic          credit_add;

    // Saturates instead of wrapping
    assign credit_add = rx_credit && (credits != '1);

    // Credit and word both present
    assign fifo_rd = (credits != '0) && !fifo_empty;

    always_ff @(posedge clk) begin
        if (fifo_rd) begin
            rx_word <= fifo_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= fifo_rd;
            case ({credit_add, fifo_rd})
                2'b10: credits <= credits + 1'b1;
                2'b01: credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// ==== src/uart_subsystem.sv ====
module uart_subsystem #(
    parameter int BAUD_DIV = uart_cfg_pkg::DEFAULT_BAUD_DIV,
    parameter int BAUD_FRAC = uart_cfg_pkg::DEFAULT_BAUD_FRAC,
    parameter int TX_DEPTH = uart_cfg_pkg::DEFAULT_TX_DEPTH,
    parameter int RX_DEPTH = uart_cfg_pkg::DEFAULT_RX_DEPTH
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         tx_push,
    input  uart_types_pkg::uart_byte_t   tx_byte,
    output logic                         tx_credit,
    output logic                         txd,
    input  logic                         rxd,
    input  logic                         rx_credit,
    output logic                         rx_valid,
    output uart_types_pkg::rx_word_t     rx_word,
    output uart_types_pkg::uart_status_t status
);

    logic                       baud_tick;
    logic                       tx_fifo_empty;
    uart_types_pkg::uart_byte_t tx_fifo_data;
    logic                       rx_push;
    uart_types_pkg::rx_word_t   rx_data;
    logic                       rx_fifo_full;
    logic                       rx_fifo_empty;
    logic                       rx_fifo_rd;
    uart_types_pkg::rx_word_t   rx_fifo_data;

    uart_baud_gen #(
        .BAUD_DIV(BAUD_DIV),
        .BAUD_FRAC(BAUD_FRAC)
    ) u_baud_gen (
        .clk(clk),
        .reset(reset),
        .baud_tick(baud_tick)
    );

    ////////////////////////////////////////////////////////////
    // Transmit path
    ////////////////////////////////////////////////////////////

    // Host credits bound the writes, full is not needed
    uart_fifo #(
        .DEPTH(TX_DEPTH),
        .WORD_T(uart_types_pkg::uart_byte_t)
    ) u_tx_fifo (
        .clk(clk),
        .reset(reset),
        .wr(tx_push),
        .wr_data(tx_byte),
        .rd(tx_credit),
        .rd_data(tx_fifo_data),
        .empty(tx_fifo_empty),
        .full()
    );

    // Each pop returns one credit to the host
    uart_tx u_tx (
        .clk(clk),
        .reset(reset),
        .baud_tick(baud_tick),
        .fifo_empty(tx_fifo_empty),
        .fifo_data(tx_fifo_data),
        .tx_pop(tx_credit),
        .txd(txd)
    );

    ////////////////////////////////////////////////////////////
    // Receive path
    ////////////////////////////////////////////////////////////

    uart_rx u_rx (
        .clk(clk),
        .reset(reset),
        .baud_tick(baud_tick),
        .rxd(rxd),
        .fifo_full(rx_fifo_full),
        .rx_push(rx_push),
        .rx_data(rx_data),
        .status(status)
    );

    uart_fifo #(
        .DEPTH(RX_DEPTH),
        .WORD_T(uart_types_pkg::rx_word_t)
    ) u_rx_fifo (
        .clk(clk),
        .reset(reset),
        .wr(rx_push),
        .wr_data(rx_data),
        .rd(rx_fifo_rd),
        .rd_data(rx_fifo_data),
        .empty(rx_fifo_empty),
        .full(rx_fifo_full)
    );

    uart_rx_deliver #(
        .RX_DEPTH(RX_DEPTH)
    ) u_rx_deliver (
        .clk(clk),
        .reset(reset),
        .rx_credit(rx_credit),
        .fifo_empty(rx_fifo_empty),
        .fifo_data(rx_fifo_data),
        .fifo_rd(rx_fifo_rd),
        .rx_valid(rx_valid),
        .rx_word(rx_word)
    );

endmodule

// ==== src/uart_tx.sv ====
module uart_tx (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       baud_tick,
    input  logic                       fifo_empty,
    input  uart_types_pkg::uart_byte_t fifo_data,
    output logic                       tx_pop,
    output logic                       txd
);

    localparam int TW = $clog2(uart_cfg_pkg::OVERSAMPLE);
    localparam int BW = $clog2(uart_cfg_pkg::DATA_BITS);

    uart_types_pkg::tx_state_e  state;
    uart_types_pkg::uart_byte_t shift_reg;
    logic [TW-1:0]              tick_cnt;
    logic [BW-1:0]              bit_cnt;
    logic                       last_tick;
    logic                       last_bit;

    // Take the head byte as soon as the line is free
    assign tx_pop = (state == uart_types_pkg::TX_IDLE) && !fifo_empty;

    // 16th tick of the current bit
    assign last_tick = (tick_cnt == TW'(uart_cfg_pkg::OVERSAMPLE - 1));
    assign last_bit = (bit_cnt == BW'(uart_cfg_pkg::DATA_BITS - 1));

    ////////////////////////////////////////////////////////////
    // Shift register, LSB goes out first
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (tx_pop) begin
            shift_reg <= fifo_data;
        end else if (state == uart_types_pkg::TX_DATA && baud_tick && last_tick) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= uart_types_pkg::TX_IDLE;
            tick_cnt <= '0;
            bit_cnt <= '0;
            txd <= 1'b1;
        end else begin
            case (state)
                uart_types_pkg::TX_IDLE: begin
                    txd <= 1'b1;
                    if (tx_pop) begin
                        state <= uart_types_pkg::TX_START;
                        tick_cnt <= '0;
                        bit_cnt <= '0;
                    end
                end
                uart_types_pkg::TX_START: begin
                    if (baud_tick) begin
                        if (txd) begin
                            // First tick after the pop opens the start bit
                            txd <= 1'b0;
                        end else if (last_tick) begin
                            state <= uart_types_pkg::TX_DATA;
                            tick_cnt <= '0;
                            txd <= shift_reg[0];
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                uart_types_pkg::TX_DATA: begin
                    if (baud_tick) begin
                        if (last_tick) begin
                            tick_cnt <= '0;
                            if (last_bit) begin
                                state <= uart_types_pkg::TX_STOP;
                                txd <= 1'b1;
                            end else begin
                                // Next bit before the shift lands
                                bit_cnt <= bit_cnt + 1'b1;
                                txd <= shift_reg[1];
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                uart_types_pkg::TX_STOP: begin
                    if (baud_tick) begin
                        if (last_tick) begin
                            state <= uart_types_pkg::TX_IDLE;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                default: state <= uart_types_pkg::TX_IDLE;
            endcase
        end
    end

endmodule

// ==== src/uart_types_pkg.sv ====
package uart_types_pkg;

    ////////////////////////////////////////////////////////////
    // Payload types
    ////////////////////////////////////////////////////////////

    // One data byte as carried on the line
    typedef logic [uart_cfg_pkg::DATA_BITS-1:0] uart_byte_t;

    // Received word, width of the receive FIFO and the host output
    typedef struct packed {
        uart_byte_t data;
        // Stop bit sampled low
        logic       frame_err;
    } rx_word_t;

    // Sticky receive status, cleared only by reset
    typedef struct packed {
        logic overrun;
        logic frame_err;
    } uart_status_t;

    ////////////////////////////////////////////////////////////
    // State machines
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

endpackage

// ==== uart_subsystem.f ====
src/uart_cfg_pkg.sv
src/uart_types_pkg.sv
src/uart_baud_gen.sv
src/uart_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_rx_deliver.sv
src/uart_subsystem.sv
verif/tb_clock.sv
verif/tb_uart_subsystem.sv

// ==== verif/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    // Free-running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset held over the first rising edges
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// ==== verif/tb_uart_subsystem.sv ====
module tb_uart_subsystem;

    localparam int BAUD_DIV = 3;
    localparam int BAUD_FRAC = 1;
    localparam int TX_DEPTH = 4;
    localparam int RX_DEPTH = 4;
    localparam int DRIVE_DLY = 2;
    localparam int TABLE_LEN = 8;
    localparam int NUM_RANDOM = 6;
    localparam int NB = uart_cfg_pkg::DATA_BITS;
    localparam int OS = uart_cfg_pkg::OVERSAMPLE;
    localparam logic [31:0] SEED = 32'h79380814;

    // Sixteen ticks span whole groups of four tick periods
    localparam int BIT_CYCLES = (OS / 4) * (4 * (BAUD_DIV + 1) + BAUD_FRAC);
    // Frame bound with every tick period long
    localparam int FRAME_CYCLES = 10 * OS * (BAUD_DIV + 2);
    localparam int NUM_FRAMES = TABLE_LEN + NUM_RANDOM + RX_DEPTH + 2;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * FRAME_CYCLES * 2 + 1000;

    typedef struct packed {
        uart_types_pkg::uart_byte_t data;
        logic                       loopback;
        logic                       stop_bit;
        logic                       exp_frame_err;
    } entry_t;

    logic                         clk;
    logic                         reset;
    logic                         tx_push;
    uart_types_pkg::uart_byte_t   tx_byte;
    logic                         tx_credit;
    logic                         txd;
    logic                         rxd;
    logic                         rxd_drv;
    logic                         loopback;
    logic                         rx_credit;
    logic                         rx_valid;
    uart_types_pkg::rx_word_t     rx_word;
    uart_types_pkg::uart_status_t status;
    uart_types_pkg::uart_status_t exp_status;
    uart_types_pkg::rx_word_t     got_q [$];
    int                           next_got;
    int                           tx_pushes;
    int                           tx_pulses;
    int                           rx_given;
    int                           rx_taken;
    logic [31:0]                  rng;

    // Byte, loopback, stop bit driven, expected frame_err
    entry_t stim_table [TABLE_LEN] = '{
        '{8'h55, 1'b1, 1'b1, 1'b0},
        '{8'hA3, 1'b1, 1'b1, 1'b0},
        '{8'h00, 1'b1, 1'b1, 1'b0},
        '{8'hFF, 1'b1, 1'b1, 1'b0},
        '{8'h3C, 1'b0, 1'b1, 1'b0},
        '{8'hC5, 1'b0, 1'b0, 1'b1},
        '{8'h81, 1'b0, 1'b1, 1'b0},
        '{8'h69, 1'b1, 1'b1, 1'b0}
    };

    tb_clock #(.PERIOD(40), .RESET_CYCLES(2)) u_clock (.clk(clk), .reset(reset));

    // Line either looped back from txd or driven bit by bit
    assign rxd = loopback ? txd : rxd_drv;

    uart_subsystem #(
        .BAUD_DIV(BAUD_DIV),
        .BAUD_FRAC(BAUD_FRAC),
        .TX_DEPTH(TX_DEPTH),
        .RX_DEPTH(RX_DEPTH)
    ) u_dut (
        .clk(clk),
        .reset(reset),
        .tx_push(tx_push),
        .tx_byte(tx_byte),
        .tx_credit(tx_credit),
        .txd(txd),
        .rxd(rxd),
        .rx_credit(rx_credit),
        .rx_valid(rx_valid),
        .rx_word(rx_word),
        .status(status)
    );

    ////////////////////////////////////////////////////////////
    // Helpers and checks
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_byte(input string name, input uart_types_pkg::uart_byte_t got,
                              input uart_types_pkg::uart_byte_t exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input uart_types_pkg::rx_word_t got,
                              input uart_types_pkg::rx_word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_status(input string name, input uart_types_pkg::uart_status_t got,
                                input uart_types_pkg::uart_status_t exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR: %s got %h expected %h", name, got, exp));
        end
    endtask

    // Host transmit side, push only with a credit in hand
    task automatic push_byte(input uart_types_pkg::uart_byte_t data);
        while (TX_DEPTH - tx_pushes + tx_pulses == 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DLY;
        tx_push = 1'b1;
        tx_byte = data;
        tx_pushes++;
        @(posedge clk);
        #DRIVE_DLY;
        tx_push = 1'b0;
    endtask

    task automatic give_rx_credits(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DLY;
            rx_credit = 1'b1;
            rx_given++;
            @(posedge clk);
            #DRIVE_DLY;
            rx_credit = 1'b0;
        end
    endtask

    // Only switched while both sources idle high
    task automatic set_line(input logic use_loopback);
        @(posedge clk);
        #DRIVE_DLY;
        loopback = use_loopback;
    endtask

    task automatic drive_bit(input logic value, input int cycles);
        @(posedge clk);
        #DRIVE_DLY;
        rxd_drv = value;
        repeat (cycles - 1) @(posedge clk);
    endtask

    // Stop level released after 3/4 bit so a low stop cannot read as a new start
    task automatic drive_frame(input uart_types_pkg::uart_byte_t data, input logic stop_bit);
        int i;
        drive_bit(1'b0, BIT_CYCLES);
        for (i = 0; i < NB; i++) begin
            drive_bit(data[i], BIT_CYCLES);
        end
        drive_bit(stop_bit, BIT_CYCLES * 3 / 4);
        drive_bit(1'b1, 2 * BIT_CYCLES);
    endtask

    task automatic wait_words(input int target, input int limit);
        int waited;
        waited = 0;
        while (got_q.size() < target) begin
            @(negedge clk);
            waited++;
            if (waited > limit) begin
                fail_run("no rx_valid arrived within the expected frame time");
            end
        end
    endtask

    // Low run of a frame whose LSB is 1 is the start bit alone
    task automatic measure_start_bit;
        int waited;
        int low_cycles;
        waited = 0;
        low_cycles = 0;
        @(negedge clk);
        while (txd) begin
            waited++;
            if (waited > FRAME_CYCLES) begin
                fail_run("txd never left idle after a push");
            end
            @(negedge clk);
        end
        while (!txd) begin
            low_cycles++;
            @(negedge clk);
        end
        if (low_cycles < OS * (BAUD_DIV + 1) || low_cycles > OS * (BAUD_DIV + 2)) begin
            fail_run($sformatf("ERROR: txd start bit %h cycles expected %h to %h",
                               low_cycles, OS * (BAUD_DIV + 1), OS * (BAUD_DIV + 2)));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sections
    ////////////////////////////////////////////////////////////

    task automatic run_entry(input entry_t ent);
        uart_types_pkg::rx_word_t exp;
        set_line(ent.loopback);
        give_rx_credits(1);
        if (ent.loopback) begin
            push_byte(ent.data);
            if (ent.data[0]) begin
                measure_start_bit();
            end
        end else begin
            drive_frame(ent.data, ent.stop_bit);
        end
        wait_words(next_got + 1, 2 * FRAME_CYCLES);
        exp.data = ent.data;
        exp.frame_err = ent.exp_frame_err;
        check_word("rx_word", got_q[next_got], exp);
        next_got++;
        if (ent.exp_frame_err) begin
            exp_status.frame_err = 1'b1;
        end
        check_status("status", status, exp_status);
    endtask

    // Pushes beyond TX_DEPTH wait on returned credits
    task automatic run_burst;
        uart_types_pkg::uart_byte_t sent [$];
        uart_types_pkg::rx_word_t   exp;
        int                         i;
        set_line(1'b1);
        give_rx_credits(NUM_RANDOM);
        for (i = 0; i < NUM_RANDOM; i++) begin
            rng = xorshift32(rng);
            sent.push_back(rng[7:0]);
            push_byte(rng[7:0]);
        end
        wait_words(next_got + NUM_RANDOM, 2 * NUM_RANDOM * FRAME_CYCLES);
        for (i = 0; i < NUM_RANDOM; i++) begin
            exp.data = sent[i];
            exp.frame_err = 1'b0;
            check_word("rx_word", got_q[next_got], exp);
            next_got++;
        end
    endtask

    // Two frames more than the receive FIFO holds, no credits out
    task automatic run_overrun;
        uart_types_pkg::uart_byte_t sent [$];
        int                         i;
        set_line(1'b0);
        for (i = 0; i < RX_DEPTH + 2; i++) begin
            rng = xorshift32(rng);
            sent.push_back(rng[7:0]);
            drive_frame(rng[7:0], 1'b1);
        end
        if (got_q.size() != next_got) begin
            fail_run("a word was delivered while no receive credit was held");
        end
        exp_status.overrun = 1'b1;
        check_status("status", status, exp_status);
        give_rx_credits(RX_DEPTH);
        wait_words(next_got + RX_DEPTH, 2 * FRAME_CYCLES);
        for (i = 0; i < RX_DEPTH; i++) begin
            check_byte("rx_word.data", got_q[next_got].data, sent[i]);
            next_got++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Monitor, watchdog and main sequence
    ////////////////////////////////////////////////////////////

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (tx_credit) begin
                tx_pulses++;
                if (tx_pulses > tx_pushes) begin
                    fail_run("tx_credit returned a credit for a byte never pushed");
                end
            end
            if (rx_valid) begin
                if (rx_given - rx_taken == 0) begin
                    fail_run("rx_valid asserted while no receive credit was held");
                end
                rx_taken++;
                got_q.push_back(rx_word);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run($sformatf("run timed out after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        int e;
        tx_push = 1'b0;
        tx_byte = '0;
        rx_credit = 1'b0;
        rxd_drv = 1'b1;
        loopback = 1'b0;
        exp_status = '0;
        next_got = 0;
        tx_pushes = 0;
        tx_pulses = 0;
        rx_given = 0;
        rx_taken = 0;
        rng = SEED;
        @(negedge clk);
        while (reset) begin
            @(negedge clk);
        end
        for (e = 0; e < TABLE_LEN; e++) begin
            run_entry(stim_table[e]);
        end
        run_burst();
        run_overrun();
        // Line long idle, every credit back with the host
        if (tx_pulses != tx_pushes) begin
            fail_run($sformatf("ERROR: tx_credit pulses got %h expected %h",
                               tx_pulses, tx_pushes));
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule
